//--- tlu_pkg.sv
/* widths, trigger word and configuration structs, mode and FSM state encodings
   shared by the trigger logic unit controller */
package tlu_pkg;

    localparam int LATCH_MARGIN = 5; // sync cycles added to data_delay before latching

    typedef logic [31:0] trigger_count_t;
    typedef logic [30:0] tlu_number_t;  // zero-extended TLU trigger number
    typedef logic [7:0]  cycle_count_t; // threshold, handshake wait, high time
    typedef logic [3:0]  data_delay_t;  // cable delay in cycles

    typedef enum logic [1:0] {
        MODE_EXTERNAL = 2'd0,
        MODE_TLU_DATA = 2'd3 // 1 and 2 keep the unit idle
    } trigger_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND_COMMAND,
        WAIT_FOR_TRIGGER_LOW,
        SEND_TLU_CLOCK,
        WAIT_BEFORE_LATCH,
        LATCH_DATA,
        WAIT_FOR_ACK
    } tlu_state_e;

    // static while the unit is enabled
    typedef struct packed {
        trigger_mode_e mode;
        cycle_count_t  threshold;
        cycle_count_t  handshake_wait_cycles;
        data_delay_t   data_delay;
        logic          msb_first;
    } tlu_config_t;

    typedef struct packed {
        logic        lead_one; // always set
        tlu_number_t number;
    } trigger_word_t;

endpackage

//--- trigger_qualifier.sv
/* trigger input register, trigger and enable edge detection, high-time
   counter and per-mode acceptance rule */
`timescale 1ns/1ps

module trigger_qualifier
    import tlu_pkg::*;
(
    input  logic        TRIGGER_CLK,
    input  logic        RESET,
    input  logic        trigger,
    input  logic        trigger_enable,
    input  logic        busy,
    input  tlu_config_t cfg,
    output logic        qualified,
    output logic        trigger_flag,
    output logic        trigger_level
);

    logic         trigger_q;
    logic         trigger_ff;
    logic         enable_ff;
    logic         enable_flag;
    cycle_count_t high_count;
    logic         external_ok;
    logic         tlu_ok;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_q  <= 1'b0;
            trigger_ff <= 1'b0;
            enable_ff  <= 1'b0;
        end
        else
        begin
            trigger_q  <= trigger; // one input stage so acceptance lands one cycle after the edge
            trigger_ff <= trigger_q;
            enable_ff  <= trigger_enable;
        end
    end

    assign trigger_level = trigger_q;
    assign trigger_flag  = trigger_q & ~trigger_ff;
    assign enable_flag   = trigger_enable & ~enable_ff;

    // consecutive high cycles started only by an edge so a held trigger fires once
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || busy || !trigger_enable || !trigger_q)
            high_count <= '0;
        else if ((high_count != '0 || trigger_flag) && high_count != '1)
            high_count <= high_count + 1'b1; // saturates at 255
    end

    // edge sample plus threshold more high samples
    assign external_ok = (cfg.threshold == '0) ? trigger_flag
                                               : (trigger_q && high_count >= cfg.threshold);

    // trigger already high when enabled counts as a handshake request
    assign tlu_ok = (trigger_q && enable_flag)
                 || (trigger_flag && cfg.handshake_wait_cycles == '0)
                 || (cfg.handshake_wait_cycles != '0
                     && high_count >= cfg.handshake_wait_cycles);

    always_comb
    begin
        qualified = 1'b0;
        if (trigger_enable && !busy)
        begin
            case (cfg.mode)
                MODE_EXTERNAL: qualified = external_ok;
                MODE_TLU_DATA: qualified = tlu_ok;
                default:       qualified = 1'b0;
            endcase
        end
    end

    // a qualified trigger is taken by the FSM and never re-qualified while busy
    a_qualified_taken: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        qualified |=> (busy && !qualified))
        else $error("qualified trigger not taken up by the handshake FSM");

endmodule

//--- tlu_serial_receiver.sv
/* serial-to-parallel shift register on the trigger line and TLU trigger
   number extraction at the latch strobe */
`timescale 1ns/1ps

module tlu_serial_receiver
    import tlu_pkg::*;
#(
    parameter int DIVISOR              = 8,
    parameter int TLU_MAX_CLOCK_CYCLES = 17
) (
    input  logic        TRIGGER_CLK,
    input  logic        RESET,
    input  logic        trigger,
    input  logic        clear,
    input  logic        latch,
    input  logic        msb_first,
    output tlu_number_t tlu_number
);

    localparam int SR_WIDTH = (TLU_MAX_CLOCK_CYCLES + 1) * DIVISOR;
    localparam int RAW_BITS = TLU_MAX_CLOCK_CYCLES - 1; // start window carries no data
    localparam int NUM_BITS = (RAW_BITS > 31) ? 31 : RAW_BITS;

    logic [SR_WIDTH-1:0] shift_reg;
    tlu_number_t         extracted;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || clear)
            shift_reg <= '0;
        else
            shift_reg <= {shift_reg[SR_WIDTH-2:0], trigger}; // newest sample at bit 0
    end

    // window 0 holds the last data bit sent, the start bit sits above the data windows
    always_comb
    begin
        extracted = '0;
        for (int i = 0; i < NUM_BITS; i++)
        begin
            if (msb_first)
                extracted[i] = shift_reg[(i + 1) * DIVISOR - 1];
            else
                extracted[i] = shift_reg[(NUM_BITS - i) * DIVISOR - 1]; // lsb sent first
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            tlu_number <= '0;
        else if (latch)
            tlu_number <= extracted; // valid the cycle after latch
    end

endmodule

//--- trigger_word_builder.sv
/* internal trigger counter with load, count snapshot and trigger word assembly */
`timescale 1ns/1ps

module trigger_word_builder
    import tlu_pkg::*;
(
    input  logic           TRIGGER_CLK,
    input  logic           RESET,
    input  logic           accepted_flag,
    input  logic           latch,
    input  logic           counter_set,
    input  trigger_count_t counter_set_value,
    input  trigger_mode_e  mode,
    input  tlu_number_t    tlu_number,
    output trigger_word_t  trigger_data
);

    trigger_count_t trigger_count;
    trigger_count_t count_snapshot;
    tlu_number_t    count_word;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_count <= '0;
        else if (counter_set) // load wins over counting
            trigger_count <= counter_set_value;
        else if (accepted_flag)
            trigger_count <= trigger_count + 1'b1;
    end

    // count as it stood when the trigger was accepted
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (accepted_flag)
            count_snapshot <= trigger_count;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (latch)
            count_word <= count_snapshot[30:0]; // lines up with the received number
    end

    assign trigger_data.lead_one = 1'b1;
    assign trigger_data.number   = (mode == MODE_TLU_DATA) ? tlu_number : count_word;

endmodule

//--- tlu_handshake_fsm.sv
/* trigger handshake FSM with TLU clock and latch-delay counters, sticky
   acknowledge flags and registered control outputs */
`timescale 1ns/1ps

module tlu_handshake_fsm
    import tlu_pkg::*;
#(
    parameter int DIVISOR              = 8,
    parameter int TLU_MAX_CLOCK_CYCLES = 17
) (
    input  logic        TRIGGER_CLK,
    input  logic        RESET,
    input  tlu_config_t cfg,
    input  logic        trigger_enable,
    input  logic        trigger,
    input  logic        trigger_flag,
    input  logic        qualified,
    input  logic        trigger_acknowledge,
    input  logic        fifo_acknowledge,
    output logic        accepted_flag,
    output logic        latch,
    output logic        trigger_data_write,
    output logic        fifo_preempt_req,
    output logic        tlu_busy,
    output logic        tlu_clock_enable
);

    localparam int CLOCK_CYCLES = TLU_MAX_CLOCK_CYCLES * DIVISOR;
    localparam int CLK_CNT_W    = $clog2(CLOCK_CYCLES + 1);

    tlu_state_e           state;
    tlu_state_e           next;
    logic [CLK_CNT_W-1:0] clock_count;
    logic [4:0]           wait_count;
    logic [4:0]           wait_target;
    logic                 trigger_ack_seen;
    logic                 fifo_ack_seen;
    logic                 both_acked;

    // LATCH_DATA and the latch register take two of the margin cycles
    assign wait_target = 5'(cfg.data_delay) + 5'(LATCH_MARGIN - 2);

    assign both_acked = (trigger_ack_seen || trigger_acknowledge)
                     && (fifo_ack_seen || fifo_acknowledge);

    always_comb
    begin
        next = state;
        case (state)
            IDLE:
            begin
                if (trigger_enable && qualified)
                begin
                    if (cfg.mode == MODE_EXTERNAL)
                        next = SEND_COMMAND;
                    else if (cfg.mode == MODE_TLU_DATA)
                        next = WAIT_FOR_TRIGGER_LOW;
                end
            end
            SEND_COMMAND:         next = LATCH_DATA; // no need to wait for trigger low
            WAIT_FOR_TRIGGER_LOW:
            begin
                if (!trigger)
                    next = SEND_TLU_CLOCK;
            end
            SEND_TLU_CLOCK:
            begin
                if (clock_count == CLK_CNT_W'(CLOCK_CYCLES - 1))
                    next = WAIT_BEFORE_LATCH;
            end
            WAIT_BEFORE_LATCH:
            begin
                if (wait_count == wait_target)
                    next = LATCH_DATA;
            end
            LATCH_DATA:           next = WAIT_FOR_ACK;
            WAIT_FOR_ACK:
            begin
                if (both_acked && !latch) // hold busy over the data write
                    next = IDLE;
            end
            default:              next = IDLE;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state              <= IDLE;
            accepted_flag      <= 1'b0;
            latch              <= 1'b0;
            trigger_data_write <= 1'b0;
            fifo_preempt_req   <= 1'b0;
            tlu_busy           <= 1'b0;
            tlu_clock_enable   <= 1'b0;
        end
        else
        begin
            state              <= next;
            accepted_flag      <= (state == IDLE) && (next != IDLE);
            latch              <= (state == LATCH_DATA); // strobe trails the state
            trigger_data_write <= latch;
            fifo_preempt_req   <= (next != IDLE);
            tlu_busy           <= (next != IDLE);
            tlu_clock_enable   <= (next == SEND_TLU_CLOCK);
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            clock_count      <= '0;
            wait_count       <= '0;
            trigger_ack_seen <= 1'b0;
            fifo_ack_seen    <= 1'b0;
        end
        else
        begin
            clock_count <= (state == SEND_TLU_CLOCK) ? clock_count + 1'b1 : '0;
            wait_count  <= (state == WAIT_BEFORE_LATCH) ? wait_count + 1'b1 : '0;
            if (state == IDLE)
            begin
                trigger_ack_seen <= 1'b0;
                fifo_ack_seen    <= 1'b0;
            end
            else
            begin
                if (trigger_acknowledge)
                    trigger_ack_seen <= 1'b1;
                if (fifo_acknowledge)
                    fifo_ack_seen <= 1'b1;
            end
        end
    end

    a_clock_in_tlu_mode: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        tlu_clock_enable |-> (cfg.mode == MODE_TLU_DATA))
        else $error("TLU clock enabled outside TLU data mode");

    a_write_while_busy: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |-> tlu_busy)
        else $error("trigger word written while not busy");

    // threshold-free external acceptance needs a fresh edge from the qualifier
    a_edge_accept: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        (state == IDLE && next == SEND_COMMAND && cfg.threshold == '0) |-> trigger_flag)
        else $error("external trigger accepted without an edge");

endmodule

//--- tlu_controller.sv
/* trigger logic unit controller top, joins qualifier, serial receiver,
   word builder and handshake FSM */
`timescale 1ns/1ps

module tlu_controller
    import tlu_pkg::*;
#(
    parameter int DIVISOR              = 8,  // TLU clock period in cycles
    parameter int TLU_MAX_CLOCK_CYCLES = 17
) (
    input  logic           TRIGGER_CLK,
    input  logic           RESET,
    input  logic           trigger,
    input  logic           trigger_enable,
    input  logic           trigger_acknowledge,
    input  logic           fifo_acknowledge,
    input  logic           counter_set,
    input  trigger_count_t counter_set_value,
    input  tlu_config_t    cfg,
    output logic           trigger_data_write,
    output trigger_word_t  trigger_data,
    output logic           trigger_accepted_flag,
    output logic           fifo_preempt_req,
    output logic           tlu_busy,
    output logic           tlu_clock_enable
);

    logic        qualified;
    logic        trigger_flag;
    logic        trigger_level;
    logic        latch;
    tlu_number_t tlu_number;

    trigger_qualifier trigger_qualifier_inst (
        .TRIGGER_CLK    (TRIGGER_CLK),
        .RESET          (RESET),
        .trigger        (trigger),
        .trigger_enable (trigger_enable),
        .busy           (tlu_busy),
        .cfg            (cfg),
        .qualified      (qualified),
        .trigger_flag   (trigger_flag),
        .trigger_level  (trigger_level)
    );

    tlu_serial_receiver #(
        .DIVISOR              (DIVISOR),
        .TLU_MAX_CLOCK_CYCLES (TLU_MAX_CLOCK_CYCLES)
    ) tlu_serial_receiver_inst (
        .TRIGGER_CLK (TRIGGER_CLK),
        .RESET       (RESET),
        .trigger     (trigger), // raw line, alignment set by the latch delay
        .clear       (trigger_accepted_flag),
        .latch       (latch),
        .msb_first   (cfg.msb_first),
        .tlu_number  (tlu_number)
    );

    trigger_word_builder trigger_word_builder_inst (
        .TRIGGER_CLK       (TRIGGER_CLK),
        .RESET             (RESET),
        .accepted_flag     (trigger_accepted_flag),
        .latch             (latch),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value),
        .mode              (cfg.mode),
        .tlu_number        (tlu_number),
        .trigger_data      (trigger_data)
    );

    tlu_handshake_fsm #(
        .DIVISOR              (DIVISOR),
        .TLU_MAX_CLOCK_CYCLES (TLU_MAX_CLOCK_CYCLES)
    ) tlu_handshake_fsm_inst (
        .TRIGGER_CLK         (TRIGGER_CLK),
        .RESET               (RESET),
        .cfg                 (cfg),
        .trigger_enable      (trigger_enable),
        .trigger             (trigger_level),
        .trigger_flag        (trigger_flag),
        .qualified           (qualified),
        .trigger_acknowledge (trigger_acknowledge),
        .fifo_acknowledge    (fifo_acknowledge),
        .accepted_flag       (trigger_accepted_flag),
        .latch               (latch),
        .trigger_data_write  (trigger_data_write),
        .fifo_preempt_req    (fifo_preempt_req),
        .tlu_busy            (tlu_busy),
        .tlu_clock_enable    (tlu_clock_enable)
    );

endmodule

//--- tb_tlu_controller.sv
/* testbench for the trigger logic unit controller with random stimulus,
   TLU responder, expected-counter model and checks */
`timescale 1ns/1ps

module tb_tlu_controller
    import tlu_pkg::*;
();

    localparam int DIVISOR      = 8;
    localparam int TLU_CLOCKS   = 17;
    localparam int NUMBER_BITS  = TLU_CLOCKS - 1;      // start window carries no data
    localparam int CLOCK_WINDOW = TLU_CLOCKS * DIVISOR; // TLU clock enable length
    localparam int WAIT_LIMIT   = 400;

    logic           TRIGGER_CLK;
    logic           RESET;
    logic           trigger;
    logic           trigger_enable;
    logic           trigger_acknowledge;
    logic           fifo_acknowledge;
    logic           counter_set;
    trigger_count_t counter_set_value;
    tlu_config_t    cfg;
    logic           trigger_data_write;
    trigger_word_t  trigger_data;
    logic           trigger_accepted_flag;
    logic           fifo_preempt_req;
    logic           tlu_busy;
    logic           tlu_clock_enable;

    integer         seed;
    int             error_count = 0;
    int             accept_count = 0;
    int             write_count = 0;
    trigger_count_t expected_count;

    tlu_controller tlu_controller_inst (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .fifo_acknowledge      (fifo_acknowledge),
        .counter_set           (counter_set),
        .counter_set_value     (counter_set_value),
        .cfg                   (cfg),
        .trigger_data_write    (trigger_data_write),
        .trigger_data          (trigger_data),
        .trigger_accepted_flag (trigger_accepted_flag),
        .fifo_preempt_req      (fifo_preempt_req),
        .tlu_busy              (tlu_busy),
        .tlu_clock_enable      (tlu_clock_enable)
    );

    initial
    begin
        TRIGGER_CLK = 1'b0;
        forever #4 TRIGGER_CLK = ~TRIGGER_CLK;
    end

    // pulse counters read by the main flow on falling edges
    always @(posedge TRIGGER_CLK)
    begin
        if (!RESET)
        begin
            if (trigger_accepted_flag)
                accept_count++;
            if (trigger_data_write)
                write_count++;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            fail_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                               what, expected, actual));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        integer value;
        value = $random(seed);
        return lo + int'($unsigned(value) % (hi - lo + 1));
    endfunction

    // level on the trigger line at a position of the TLU answer
    function automatic logic serial_level(input logic [15:0] number, input int pos,
                                          input logic msb_first);
        int bit_index;
        if (pos < 0)
            return 1'b0;
        if (pos < DIVISOR)
            return 1'b1; // start bit
        bit_index = (pos - DIVISOR) / DIVISOR;
        if (bit_index >= NUMBER_BITS)
            return 1'b0;
        return msb_first ? number[NUMBER_BITS - 1 - bit_index] : number[bit_index];
    endfunction

    task automatic configure(input trigger_mode_e mode, input int threshold, input int hs_wait,
                             input int delay, input logic msb_first);
        @(negedge TRIGGER_CLK);
        trigger_enable = 1'b0;
        repeat (2) @(negedge TRIGGER_CLK);
        cfg.mode                  = mode;
        cfg.threshold             = cycle_count_t'(threshold);
        cfg.handshake_wait_cycles = cycle_count_t'(hs_wait);
        cfg.data_delay            = data_delay_t'(delay);
        cfg.msb_first             = msb_first;
        @(negedge TRIGGER_CLK);
        trigger_enable = 1'b1;
        repeat (2) @(negedge TRIGGER_CLK);
    endtask

    task automatic load_counter(input trigger_count_t value);
        @(negedge TRIGGER_CLK);
        counter_set       = 1'b1;
        counter_set_value = value;
        @(negedge TRIGGER_CLK);
        counter_set    = 1'b0;
        expected_count = value;
    endtask

    // acknowledges in random order and delay plus a trigger pulse that must be ignored
    task automatic release_busy();
        int t;
        int trig_ack_at;
        int fifo_ack_at;
        int last;
        int acc0;
        trig_ack_at = rand_range(3, 10);
        fifo_ack_at = rand_range(3, 10);
        last = (trig_ack_at > fifo_ack_at) ? trig_ack_at : fifo_ack_at;
        acc0 = accept_count;
        for (t = 1; t <= last + 1; t++)
        begin
            @(negedge TRIGGER_CLK);
            check_value("busy while acknowledges pending", {31'b0, t <= last}, {31'b0, tlu_busy});
            check_value("preempt while acknowledges pending", {31'b0, t <= last},
                        {31'b0, fifo_preempt_req});
            trigger             = (t == 1 || t == 2);
            trigger_acknowledge = (t == trig_ack_at);
            fifo_acknowledge    = (t == fifo_ack_at);
        end
        repeat (3) @(negedge TRIGGER_CLK);
        check_value("trigger accepted while busy", acc0, accept_count);
        check_value("busy after both acknowledges", 32'd0, {31'b0, tlu_busy});
    endtask

    task automatic external_trigger(input int pulse_len);
        int t;
        int t_flag;
        int acc0;
        int wr0;
        logic [31:0] expected_word;
        expected_word = {1'b1, expected_count[30:0]};
        acc0 = accept_count;
        wr0  = write_count;
        t_flag = -1;
        t = 0;
        @(negedge TRIGGER_CLK);
        trigger = 1'b1;
        while (!trigger_data_write)
        begin
            @(negedge TRIGGER_CLK);
            t++;
            if (t == pulse_len)
                trigger = 1'b0;
            if (trigger_accepted_flag && t_flag < 0)
                t_flag = t;
            if (t > WAIT_LIMIT)
                fail_run("timeout waiting for the external trigger word write");
        end
        trigger = 1'b0;
        check_value("accepted flag before write", 32'd1, {31'b0, t_flag > 0});
        if (cfg.threshold == '0)
            check_value("external accept latency", 32'd2, t_flag);
        check_value("write after accepted flag", 32'd3, t - t_flag);
        check_value("external trigger word", expected_word, trigger_data);
        expected_count++;
        release_busy();
        check_value("accepted flags per trigger", 32'd1, accept_count - acc0);
        check_value("writes per trigger", 32'd1, write_count - wr0);
    endtask

    task automatic short_pulse(input int length, input int idle_cycles, input string what);
        int acc0;
        int wr0;
        acc0 = accept_count;
        wr0  = write_count;
        @(negedge TRIGGER_CLK);
        trigger = 1'b1;
        repeat (length) @(negedge TRIGGER_CLK);
        trigger = 1'b0;
        repeat (idle_cycles) @(negedge TRIGGER_CLK);
        check_value({what, " accepted"}, acc0, accept_count);
        check_value({what, " written"}, wr0, write_count);
        check_value({what, " busy"}, 32'd0, {31'b0, tlu_busy});
    endtask

    // TLU side requests, drops the line on busy and answers with start bit and number
    task automatic tlu_trigger(input logic [15:0] number);
        int t;
        int enable_cycles;
        int delay;
        int acc0;
        int wr0;
        logic [31:0] expected_word;
        expected_word = {16'h8000, number};
        acc0  = accept_count;
        wr0   = write_count;
        delay = int'(cfg.data_delay);
        @(negedge TRIGGER_CLK);
        trigger = 1'b1;
        t = 0;
        while (!tlu_busy)
        begin
            @(negedge TRIGGER_CLK);
            t++;
            if (t > WAIT_LIMIT)
                fail_run("timeout waiting for busy after a TLU trigger");
        end
        trigger = 1'b0;
        t = 0;
        while (!tlu_clock_enable)
        begin
            @(negedge TRIGGER_CLK);
            t++;
            if (t > WAIT_LIMIT)
                fail_run("timeout waiting for the TLU clock enable");
        end
        enable_cycles = 0;
        for (t = 0; t <= delay + CLOCK_WINDOW; t++)
        begin
            if (t > 0)
                @(negedge TRIGGER_CLK);
            if (tlu_clock_enable)
                enable_cycles++;
            trigger = serial_level(number, t - delay, cfg.msb_first); // cable delay
        end
        check_value("TLU clock enable length", CLOCK_WINDOW, enable_cycles);
        t = 0;
        while (!trigger_data_write)
        begin
            @(negedge TRIGGER_CLK);
            t++;
            if (t > WAIT_LIMIT)
                fail_run("timeout waiting for the TLU trigger word write");
        end
        check_value("TLU trigger word", expected_word, trigger_data);
        expected_count++; // counter runs in TLU mode too
        release_busy();
        check_value("TLU accepted flags", 32'd1, accept_count - acc0);
        check_value("TLU writes", 32'd1, write_count - wr0);
    endtask

    initial
    begin
        int n;
        int thr;
        trigger_count_t load_value;
        seed                = 84385;
        RESET               = 1'b1;
        trigger             = 1'b0;
        trigger_enable      = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_acknowledge    = 1'b0;
        counter_set         = 1'b0;
        counter_set_value   = '0;
        cfg                 = '0;
        expected_count      = '0;
        repeat (3) @(negedge TRIGGER_CLK);
        RESET = 1'b0;
        @(negedge TRIGGER_CLK);
        check_value("busy after reset", 32'd0, {31'b0, tlu_busy});
        check_value("preempt after reset", 32'd0, {31'b0, fifo_preempt_req});
        check_value("clock enable after reset", 32'd0, {31'b0, tlu_clock_enable});
        check_value("write after reset", 32'd0, {31'b0, trigger_data_write});

        // edge triggered external mode
        configure(MODE_EXTERNAL, 0, 0, 0, 1'b0);
        repeat (6) external_trigger(rand_range(1, 5));

        load_value = $random(seed);
        load_counter(load_value);
        repeat (2) external_trigger(rand_range(1, 5));

        // threshold needs the edge sample plus threshold more high samples
        thr = rand_range(2, 9);
        configure(MODE_EXTERNAL, thr, 0, 0, 1'b0);
        repeat (4)
        begin
            short_pulse(rand_range(1, thr), thr + 8, "pulse within threshold");
            external_trigger(thr + 4);
        end

        for (n = 0; n < 2; n++)
        begin
            configure(MODE_TLU_DATA, 0, rand_range(0, 6), rand_range(0, 15), n == 1);
            repeat (3) tlu_trigger(16'(rand_range(0, 65535)));
        end

        // disabled modes and disabled input
        configure(trigger_mode_e'(2'd1), 0, 0, 0, 1'b0);
        short_pulse(3, 12, "trigger in mode 1");
        configure(trigger_mode_e'(2'd2), 0, 0, 0, 1'b0);
        short_pulse(3, 12, "trigger in mode 2");
        configure(MODE_EXTERNAL, 0, 0, 0, 1'b0);
        @(negedge TRIGGER_CLK);
        trigger_enable = 1'b0;
        short_pulse(3, 12, "trigger while disabled");
        configure(MODE_EXTERNAL, 0, 0, 0, 1'b0);
        external_trigger(2); // counter untouched by ignored triggers

        if (error_count == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("Simulation finished: FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- files.f
tlu_pkg.sv
trigger_qualifier.sv
tlu_serial_receiver.sv
trigger_word_builder.sv
tlu_handshake_fsm.sv
tlu_controller.sv
tb_tlu_controller.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tlu_controller
FILELIST  = files.f
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
